//--- Makefile
VERILATOR ?= verilator
TOP ?= issueQueueTb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/issueQueueTb.sv
`timescale 1ns/1ps

module issueQueueTb
	import coreTypesPkg::*;
	import issueCfgPkg::*;
();

	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 10;
	localparam int RING = 16;
	// per-test budgets in cycles plus margin
	localparam int CYCLE_LIMIT = RESET_CYCLES + 20 + 30 + 40 + 50 + 40 + 120 + 200;

	logic clk;
	logic reset_i;
	logic enq_i;
	payloadT enqPayload_i;
	tagT enqSrcTag_i;
	logic enqSrcReady_i;
	logic wakeup_i;
	tagT wakeupTag_i;
	logic stall_i;
	logic redirect_i;
	robIdxT redirectRobIdx_i;
	logic full_o;
	logic issue_o;
	payloadT issuePayload_o;
	robIdxT issueRobIdx_o;

	// reference model with one slot per ring position
	logic mValid [RING];
	logic mReady [RING];
	tagT mTag [RING];
	robIdxT mIdx [RING];
	payloadT mPayload [RING];
	robIdxT mAlloc;
	logic mSquash;
	robIdxT mSquashIdx;

	logic expSelValid;
	logic [ROB_BITS-1:0] expSelPos;
	int expCount;
	logic expFull;
	logic expIssue;
	robIdxT expIssueIdx;
	payloadT expIssuePayload;

	string curTest;
	int errCount;
	int errAtStart;
	int testsRun;
	int testsFailed;
	int cycleCount;
	int seedDummy;

	issueQueue dut0 (
		.clk(clk),
		.reset_i(reset_i),
		.enq_i(enq_i),
		.enqPayload_i(enqPayload_i),
		.enqSrcTag_i(enqSrcTag_i),
		.enqSrcReady_i(enqSrcReady_i),
		.wakeup_i(wakeup_i),
		.wakeupTag_i(wakeupTag_i),
		.stall_i(stall_i),
		.redirect_i(redirect_i),
		.redirectRobIdx_i(redirectRobIdx_i),
		.full_o(full_o),
		.issue_o(issue_o),
		.issuePayload_o(issuePayload_o),
		.issueRobIdx_o(issueRobIdx_o)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// differing flags make the larger position older
	function automatic logic olderThan(robIdxT a, robIdxT b);
		if (a[0] != b[0]) begin
			return a[ROB_BITS:1] > b[ROB_BITS:1];
		end
		return a[ROB_BITS:1] < b[ROB_BITS:1];
	endfunction

	function automatic robIdxT successorOf(robIdxT idx);
		if (idx[ROB_BITS:1] == {ROB_BITS{1'b1}}) begin
			return {{ROB_BITS{1'b0}}, ~idx[0]};
		end
		return {idx[ROB_BITS:1] + 1'b1, idx[0]};
	endfunction

	always_comb begin
		expSelValid = 1'b0;
		expSelPos = '0;
		expCount = 0;
		for (int p = 0; p < RING; p++) begin
			if (mValid[p]) begin
				expCount = expCount + 1;
			end
			if (mValid[p] && mReady[p]) begin
				if (!expSelValid || olderThan(mIdx[p], mIdx[expSelPos])) begin
					expSelValid = 1'b1;
					expSelPos = ROB_BITS'(p);
				end
			end
		end
	end

	assign expFull = expCount == IQ_SIZE || mSquash;
	assign expIssue = expSelValid && !stall_i && !mSquash;
	assign expIssueIdx = mIdx[expSelPos];
	assign expIssuePayload = mPayload[expSelPos];

	always @(posedge clk) begin : modelUpdate
		logic doIssue;
		logic [ROB_BITS-1:0] issuePos;
		logic accept;
		logic [ROB_BITS-1:0] newPos;
		doIssue = expIssue;
		issuePos = expSelPos;
		accept = enq_i && !expFull;
		if (reset_i) begin
			for (int p = 0; p < RING; p++) begin
				mValid[p] = 1'b0;
			end
			mAlloc = '0;
			mSquash = 1'b0;
			mSquashIdx = '0;
		end else begin
			if (mSquash) begin
				for (int p = 0; p < RING; p++) begin
					if (mValid[p] && olderThan(mSquashIdx, mIdx[p])) begin
						mValid[p] = 1'b0;
					end
				end
				mAlloc = successorOf(mSquashIdx);
				mSquash = 1'b0;
			end else if (redirect_i) begin
				mSquash = 1'b1;
				mSquashIdx = redirectRobIdx_i;
			end
			for (int p = 0; p < RING; p++) begin
				if (wakeup_i && mValid[p] && mTag[p] == wakeupTag_i) begin
					mReady[p] = 1'b1;
				end
			end
			if (doIssue) begin
				mValid[issuePos] = 1'b0;
			end
			if (accept) begin
				newPos = mAlloc[ROB_BITS:1];
				mValid[newPos] = 1'b1;
				mReady[newPos] = enqSrcReady_i || (wakeup_i && wakeupTag_i == enqSrcTag_i);
				mTag[newPos] = enqSrcTag_i;
				mIdx[newPos] = mAlloc;
				mPayload[newPos] = enqPayload_i;
				mAlloc = successorOf(mAlloc);
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic flagMismatch(string what, logic [31:0] expV, logic [31:0] actV);
		errCount++;
		$display("ERR %s: %s expected %0h actual %0h", curTest, what, expV, actV);
	endtask

	assert property (@(posedge clk) $fell(reset_i) |-> !issue_o && !full_o)
		else flagMismatch("issue_o,full_o after reset", 32'd0,
			{30'd0, $sampled(issue_o), $sampled(full_o)});

	assert property (@(posedge clk) disable iff (reset_i) issue_o == expIssue)
		else flagMismatch("issue_o", $sampled(expIssue), $sampled(issue_o));

	assert property (@(posedge clk) disable iff (reset_i) full_o == expFull)
		else flagMismatch("full_o", $sampled(expFull), $sampled(full_o));

	assert property (@(posedge clk) disable iff (reset_i)
		expIssue |-> issueRobIdx_o == expIssueIdx)
		else flagMismatch("issueRobIdx_o", $sampled(expIssueIdx), $sampled(issueRobIdx_o));

	assert property (@(posedge clk) disable iff (reset_i)
		expIssue |-> issuePayload_o == expIssuePayload)
		else flagMismatch("issuePayload_o", $sampled(expIssuePayload),
			$sampled(issuePayload_o));

	task automatic startTest(string name);
		curTest = name;
		errAtStart = errCount;
	endtask

	task automatic endTest();
		testsRun++;
		if (errCount == errAtStart) begin
			$display("test %s: ok", curTest);
		end else begin
			testsFailed++;
			$display("test %s: %0d error(s)", curTest, errCount - errAtStart);
		end
	endtask

	// source holds off while full_o is high
	task automatic enqueueOne(logic srcReady, tagT tag);
		while (full_o) begin
			@(negedge clk);
		end
		enq_i = 1'b1;
		enqPayload_i = payloadT'($urandom);
		enqSrcTag_i = tag;
		enqSrcReady_i = srcReady;
		@(negedge clk);
		enq_i = 1'b0;
	endtask

	task automatic broadcastTag(tagT tag);
		wakeup_i = 1'b1;
		wakeupTag_i = tag;
		@(negedge clk);
		wakeup_i = 1'b0;
	endtask

	task automatic waitEmpty();
		while (expCount != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic oldestFirstOrder();
		startTest("oldest first");
		stall_i = 1'b1;
		repeat (5) enqueueOne(1'b1, tagT'($urandom));
		stall_i = 1'b0;
		waitEmpty();
		endTest();
	endtask

	task automatic wakeupParked();
		tagT waitTag;
		tagT sameTag;
		startTest("wakeup");
		waitTag = tagT'($urandom);
		sameTag = waitTag ^ 5'd1;
		enqueueOne(1'b0, waitTag);
		enqueueOne(1'b1, waitTag ^ 5'd2);
		enqueueOne(1'b1, waitTag ^ 5'd3);
		while (expCount > 1) begin
			@(negedge clk);
		end
		// parked entry must stay put
		repeat (3) @(negedge clk);
		broadcastTag(waitTag);
		waitEmpty();
		// tag broadcast together with the enqueue
		wakeup_i = 1'b1;
		wakeupTag_i = sameTag;
		enqueueOne(1'b0, sameTag);
		wakeup_i = 1'b0;
		waitEmpty();
		endTest();
	endtask

	task automatic fillPastFull();
		startTest("full");
		stall_i = 1'b1;
		repeat (IQ_SIZE) enqueueOne(1'b1, tagT'($urandom));
		// strobe while full gets dropped
		enq_i = 1'b1;
		enqPayload_i = payloadT'($urandom);
		enqSrcReady_i = 1'b1;
		@(negedge clk);
		enq_i = 1'b0;
		stall_i = 1'b0;
		waitEmpty();
		enqueueOne(1'b1, tagT'($urandom));
		waitEmpty();
		endTest();
	endtask

	task automatic redirectSquash();
		robIdxT redirIdx;
		startTest("redirect");
		redirIdx = '0;
		stall_i = 1'b1;
		for (int i = 0; i < 6; i++) begin
			if (i == 2) begin
				redirIdx = mAlloc;
			end
			enqueueOne(1'b1, tagT'($urandom));
		end
		stall_i = 1'b0;
		redirect_i = 1'b1;
		redirectRobIdx_i = redirIdx;
		@(negedge clk);
		redirect_i = 1'b0;
		enqueueOne(1'b1, tagT'($urandom));
		enqueueOne(1'b1, tagT'($urandom));
		waitEmpty();
		endTest();
	endtask

	task automatic wrapRing();
		int sent;
		startTest("wraparound");
		sent = 0;
		while (sent < 20) begin
			stall_i = ($urandom % 4) == 0;
			wakeup_i = ($urandom % 2) == 1;
			wakeupTag_i = tagT'($urandom % 4);
			enq_i = 1'b0;
			if (!full_o) begin
				enq_i = 1'b1;
				enqPayload_i = payloadT'($urandom);
				enqSrcTag_i = tagT'($urandom % 4);
				enqSrcReady_i = ($urandom % 4) != 0;
				sent++;
			end
			@(negedge clk);
		end
		enq_i = 1'b0;
		wakeup_i = 1'b0;
		stall_i = 1'b0;
		for (int t = 0; t < 4; t++) begin
			broadcastTag(tagT'(t));
		end
		waitEmpty();
		endTest();
	endtask

	initial begin
		seedDummy = $urandom(32'h6fcb48ef);
		errCount = 0;
		errAtStart = 0;
		testsRun = 0;
		testsFailed = 0;
		cycleCount = 0;
		reset_i = 1'b1;
		enq_i = 1'b0;
		enqPayload_i = '0;
		enqSrcTag_i = '0;
		enqSrcReady_i = 1'b0;
		wakeup_i = 1'b0;
		wakeupTag_i = '0;
		stall_i = 1'b0;
		redirect_i = 1'b0;
		redirectRobIdx_i = '0;
		startTest("reset");
		repeat (RESET_CYCLES) @(negedge clk);
		reset_i = 1'b0;
		// first index after reset is zero
		enqueueOne(1'b1, tagT'($urandom));
		waitEmpty();
		endTest();
		oldestFirstOrder();
		wakeupParked();
		fillPastFull();
		redirectSquash();
		wrapRing();
		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- list.f
src/coreTypesPkg.sv
src/issueCfgPkg.sv
src/robIdxCounter.sv
src/iqControl.sv
src/iqEntries.sv
src/oldestSelect.sv
src/issueQueue.sv
bench/issueQueueTb.sv

//--- src/coreTypesPkg.sv
package coreTypesPkg;

	// ring index value bits for 16 positions
	localparam int ROB_BITS = 4;
	localparam int TAG_BITS = 5;
	localparam int DATA_BITS = 16;

	// position in the upper bits and wrap flag in bit 0
	typedef logic [ROB_BITS:0] robIdxT;
	typedef logic [TAG_BITS-1:0] tagT;
	typedef logic [DATA_BITS-1:0] payloadT;

	// a older than b
	function automatic logic isOlder(robIdxT a, robIdxT b);
		return (a[0] ^ b[0]) ^ (a[ROB_BITS:1] < b[ROB_BITS:1]);
	endfunction

	// wrap flag flips when the position rolls over
	function automatic robIdxT robIdxNext(robIdxT idx);
		logic [ROB_BITS-1:0] pos;
		pos = idx[ROB_BITS:1] + 1'b1;
		return {pos, idx[0] ^ (&idx[ROB_BITS:1])};
	endfunction

endpackage

//--- src/iqControl.sv
`timescale 1ns/1ps

module iqControl
	import coreTypesPkg::*;
	import issueCfgPkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic redirect_i,
	input robIdxT redirectRobIdx_i,
	input logic queueFull_i,
	input logic stall_i,
	output logic enqAllowed_o,
	output logic issueAllowed_o,
	output logic squash_o,
	output robIdxT squashIdx_o,
	output logic full_o
);

	iqStateT state;
	iqStateT stateNext;

	always_comb begin
		stateNext = state;
		case (state)
			IQ_RUN: begin
				if (redirect_i) begin
					stateNext = IQ_SQUASH;
				end
			end
			// squash lasts exactly one cycle
			IQ_SQUASH: stateNext = IQ_RUN;
			default: stateNext = IQ_RUN;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= IQ_RUN;
		end else begin
			state <= stateNext;
		end
	end

	// redirect index held for the squash cycle
	always_ff @(posedge clk) begin
		if (state == IQ_RUN && redirect_i) begin
			squashIdx_o <= redirectRobIdx_i;
		end
	end

	assign squash_o = state == IQ_SQUASH;
	assign full_o = queueFull_i || squash_o;
	assign enqAllowed_o = !full_o;
	assign issueAllowed_o = !squash_o && !stall_i;

	assert property (@(posedge clk) disable iff (reset_i)
		squash_o |=> !squash_o)
		else $error("iqControl: squash held two cycles");

endmodule

//--- src/iqEntries.sv
`timescale 1ns/1ps

module iqEntries
	import coreTypesPkg::*;
	import issueCfgPkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic enq_i,
	input logic enqAllowed_i,
	input payloadT enqPayload_i,
	input tagT enqSrcTag_i,
	input logic enqSrcReady_i,
	input robIdxT allocIdx_i,
	input logic wakeup_i,
	input tagT wakeupTag_i,
	input logic issue_i,
	input entryIdxT issueEntry_i,
	input logic squash_i,
	input robIdxT squashIdx_i,
	output entryMaskT readyMask_o,
	output robIdxT [IQ_SIZE-1:0] entryAge_o,
	output payloadT issuePayload_o,
	output robIdxT issueRobIdx_o,
	output logic queueFull_o,
	output logic enqAccepted_o
);

	entryMaskT valid;
	entryMaskT ready;
	tagT [IQ_SIZE-1:0] srcTag;
	robIdxT [IQ_SIZE-1:0] age;
	payloadT [IQ_SIZE-1:0] payload;

	entryMaskT freeOneHot;
	entryMaskT writeMask;
	entryMaskT issueMask;
	entryMaskT youngerMask;
	logic wakeNew;

	assign queueFull_o = &valid;
	assign enqAccepted_o = enq_i && enqAllowed_i;

	// lowest free entry wins
	assign freeOneHot[0] = ~valid[0];
	for (genvar i = 1; i < IQ_SIZE; i++) begin : gFree
		assign freeOneHot[i] = ~valid[i] & (&valid[i-1:0]);
	end

	assign writeMask = enqAccepted_o ? freeOneHot : '0;
	assign issueMask = issue_i ? entryMaskT'(1) << issueEntry_i : '0;

	// broadcast in the enqueue cycle also counts
	assign wakeNew = wakeup_i && wakeupTag_i == enqSrcTag_i;

	always_comb begin
		youngerMask = '0;
		for (int i = 0; i < IQ_SIZE; i++) begin
			youngerMask[i] = squash_i && isOlder(squashIdx_i, age[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid <= '0;
		end else begin
			valid <= (valid & ~issueMask & ~youngerMask) | writeMask;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < IQ_SIZE; i++) begin
			if (writeMask[i]) begin
				payload[i] <= enqPayload_i;
				srcTag[i] <= enqSrcTag_i;
				age[i] <= allocIdx_i;
				ready[i] <= enqSrcReady_i || wakeNew;
			end else if (wakeup_i && srcTag[i] == wakeupTag_i) begin
				ready[i] <= 1'b1;
			end
		end
	end

	assign readyMask_o = valid & ready;
	assign entryAge_o = age;

	// payload of the selected entry
	assign issuePayload_o = payload[issueEntry_i];
	assign issueRobIdx_o = age[issueEntry_i];

	// selector and control must agree on the issued slot
	assert property (@(posedge clk) disable iff (reset_i)
		issue_i |-> valid[issueEntry_i] && ready[issueEntry_i])
		else $error("iqEntries: issue of an entry that is not ready");

	assert property (@(posedge clk) disable iff (reset_i)
		enqAccepted_o |-> !squash_i && |freeOneHot)
		else $error("iqEntries: enqueue without a free entry");

endmodule

//--- src/issueCfgPkg.sv
package issueCfgPkg;

	localparam int IQ_SIZE = 8;
	localparam int IQ_IDX_BITS = $clog2(IQ_SIZE);

	// select tree depth and node count in heap layout
	localparam int IQ_LEVELS = 3;
	localparam int IQ_NODES = 2 * IQ_SIZE - 1;

	typedef logic [IQ_IDX_BITS-1:0] entryIdxT;
	typedef logic [IQ_SIZE-1:0] entryMaskT;

	typedef enum logic {
		IQ_RUN,
		IQ_SQUASH
	} iqStateT;

endpackage

//--- src/issueQueue.sv
`timescale 1ns/1ps

module issueQueue
	import coreTypesPkg::*;
	import issueCfgPkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic enq_i,
	input payloadT enqPayload_i,
	input tagT enqSrcTag_i,
	input logic enqSrcReady_i,
	input logic wakeup_i,
	input tagT wakeupTag_i,
	input logic stall_i,
	input logic redirect_i,
	input robIdxT redirectRobIdx_i,
	output logic full_o,
	output logic issue_o,
	output payloadT issuePayload_o,
	output robIdxT issueRobIdx_o
);

	robIdxT allocIdx;
	logic enqAllowed;
	logic enqAccepted;
	logic issueAllowed;
	logic squash;
	robIdxT squashIdx;
	logic queueFull;
	entryMaskT readyMask;
	robIdxT [IQ_SIZE-1:0] entryAge;
	logic selValid;
	entryIdxT selEntry;

	// oldest ready entry goes out unless stalled or squashing
	assign issue_o = selValid && issueAllowed;

	robIdxCounter robIdx0 (
		.clk(clk),
		.reset_i(reset_i),
		.advance_i(enqAccepted),
		.rewind_i(squash),
		.rewindIdx_i(squashIdx),
		.allocIdx_o(allocIdx)
	);

	iqControl control0 (
		.clk(clk),
		.reset_i(reset_i),
		.redirect_i(redirect_i),
		.redirectRobIdx_i(redirectRobIdx_i),
		.queueFull_i(queueFull),
		.stall_i(stall_i),
		.enqAllowed_o(enqAllowed),
		.issueAllowed_o(issueAllowed),
		.squash_o(squash),
		.squashIdx_o(squashIdx),
		.full_o(full_o)
	);

	iqEntries entries0 (
		.clk(clk),
		.reset_i(reset_i),
		.enq_i(enq_i),
		.enqAllowed_i(enqAllowed),
		.enqPayload_i(enqPayload_i),
		.enqSrcTag_i(enqSrcTag_i),
		.enqSrcReady_i(enqSrcReady_i),
		.allocIdx_i(allocIdx),
		.wakeup_i(wakeup_i),
		.wakeupTag_i(wakeupTag_i),
		.issue_i(issue_o),
		.issueEntry_i(selEntry),
		.squash_i(squash),
		.squashIdx_i(squashIdx),
		.readyMask_o(readyMask),
		.entryAge_o(entryAge),
		.issuePayload_o(issuePayload_o),
		.issueRobIdx_o(issueRobIdx_o),
		.queueFull_o(queueFull),
		.enqAccepted_o(enqAccepted)
	);

	oldestSelect select0 (
		.readyMask_i(readyMask),
		.entryAge_i(entryAge),
		.selValid_o(selValid),
		.selEntry_o(selEntry)
	);

endmodule

//--- src/oldestSelect.sv
`timescale 1ns/1ps

module oldestSelect
	import coreTypesPkg::*;
	import issueCfgPkg::*;
(
	input entryMaskT readyMask_i,
	input robIdxT [IQ_SIZE-1:0] entryAge_i,
	output logic selValid_o,
	output entryIdxT selEntry_o
);

	// heap of nodes with root at 0 and leaves from IQ_SIZE-1
	logic [IQ_NODES-1:0] nodeValid;
	robIdxT [IQ_NODES-1:0] nodeAge;
	entryIdxT [IQ_NODES-1:0] nodeIdx;

	for (genvar i = 0; i < IQ_SIZE; i++) begin : gLeaf
		assign nodeValid[IQ_SIZE-1+i] = readyMask_i[i];
		assign nodeAge[IQ_SIZE-1+i] = entryAge_i[i];
		assign nodeIdx[IQ_SIZE-1+i] = entryIdxT'(i);
	end

	for (genvar lv = 0; lv < IQ_LEVELS; lv++) begin : gLevel
		for (genvar n = 0; n < (1 << lv); n++) begin : gNode
			logic leftOk;
			logic rightOk;
			logic pickRight;

			assign leftOk = nodeValid[2*((1<<lv)-1+n)+1];
			assign rightOk = nodeValid[2*((1<<lv)-1+n)+2];

			// not ready always loses and ties go left
			assign pickRight = rightOk && (!leftOk ||
				isOlder(nodeAge[2*((1<<lv)-1+n)+2], nodeAge[2*((1<<lv)-1+n)+1]));

			assign nodeValid[(1<<lv)-1+n] = leftOk || rightOk;
			assign nodeAge[(1<<lv)-1+n] = pickRight ?
				nodeAge[2*((1<<lv)-1+n)+2] : nodeAge[2*((1<<lv)-1+n)+1];
			assign nodeIdx[(1<<lv)-1+n] = pickRight ?
				nodeIdx[2*((1<<lv)-1+n)+2] : nodeIdx[2*((1<<lv)-1+n)+1];
		end
	end

	assign selValid_o = nodeValid[0];
	assign selEntry_o = nodeIdx[0];

endmodule

//--- src/robIdxCounter.sv
`timescale 1ns/1ps

module robIdxCounter
	import coreTypesPkg::*;
(
	input logic clk,
	input logic reset_i,
	input logic advance_i,
	input logic rewind_i,
	input robIdxT rewindIdx_i,
	output robIdxT allocIdx_o
);

	robIdxT baseIdx;

	// rewind restarts just past the redirect index
	assign baseIdx = rewind_i ? rewindIdx_i : allocIdx_o;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			allocIdx_o <= '0;
		end else if (advance_i || rewind_i) begin
			allocIdx_o <= robIdxNext(baseIdx);
		end
	end

	// enqueue is blocked while the squash is applied
	assert property (@(posedge clk) disable iff (reset_i)
		!(advance_i && rewind_i))
		else $error("robIdxCounter: advance during rewind");

endmodule
